// ==== list.f ====
design/dphy_pkg.sv
design/csi2_pkg.sv
design/dphy_lane_ctrl.sv
design/hs_burst_framer.sv
design/csi2_packet_parser.sv
design/raw10_unpacker.sv
design/csi2_rx_top.sv
verification/csi2_rx_tb.sv

// ==== Bender.yml ====
package:
  name: csi2_rx

sources:
  - files:
      - design/dphy_pkg.sv
      - design/csi2_pkg.sv
      - design/dphy_lane_ctrl.sv
      - design/hs_burst_framer.sv
      - design/csi2_packet_parser.sv
      - design/raw10_unpacker.sv
      - design/csi2_rx_top.sv
  - target: simulation
    files:
      - verification/csi2_rx_tb.sv

// ==== verification/csi2_rx_tb.sv ====
`timescale 1ns/1ps

module csi2_rx_tb;

    import dphy_pkg::*;
    import csi2_pkg::*;

    localparam int          TIMEOUT_CYCLES = 300;
    localparam logic [7:0]  SYNC_BYTE      = 8'hB8;
    localparam logic [15:0] FRAME_NO       = 16'h0A31;

    logic         dphy_rx_clk;
    logic         in_reset;
    lp_state_t    lp_d0;
    lp_state_t    lp_d1;
    logic [15:0]  hs_d0;
    logic [15:0]  hs_d1;
    logic         hs_valid;
    logic [1:0]   hsrx_odten;
    logic         drst_n;
    pixel_group_t pixels;
    logic         frame_start;
    logic         frame_end;
    logic [15:0]  frame_number;
    logic         ecc_error;

    integer       seed;
    int           errors;
    int           checks;
    logic [7:0]   tx_bytes[$];      // bytes of the next burst
    logic [9:0]   pix_vals[16];
    pixel_group_t pix_q[$];         // groups seen by the monitor
    int           fs_count;
    int           fe_count;
    int           ecc_count;
    logic [15:0]  event_number;     // frame_number at the last event
    int           odt_cycles;
    int           odt_both;         // cycles with both lanes terminated
    int           drst_low;

    csi2_rx_top csi2_rx_top_inst (
        .dphy_rx_clk  (dphy_rx_clk),
        .in_reset     (in_reset),
        .lp_d0        (lp_d0),
        .lp_d1        (lp_d1),
        .hs_d0        (hs_d0),
        .hs_d1        (hs_d1),
        .hs_valid     (hs_valid),
        .hsrx_odten   (hsrx_odten),
        .drst_n       (drst_n),
        .pixels       (pixels),
        .frame_start  (frame_start),
        .frame_end    (frame_end),
        .frame_number (frame_number),
        .ecc_error    (ecc_error)
    );

    initial begin
        dphy_rx_clk = 1'b0;
        forever #5 dphy_rx_clk = ~dphy_rx_clk;
    end

    // sample just after the rising edge, inputs move on the falling one
    initial begin
        forever begin
            @(posedge dphy_rx_clk);
            #1;
            if (!in_reset) begin
                if (pixels.valid)
                    pix_q.push_back(pixels);
                if (frame_start || frame_end)
                    event_number = frame_number;
                fs_count   += frame_start;
                fe_count   += frame_end;
                ecc_count  += ecc_error;
                odt_cycles += (hsrx_odten != 2'b00);
                odt_both   += (hsrx_odten == 2'b11);
                drst_low   += !drst_n;
            end
        end
    end

    // ----------------------------------------
    // compare tasks
    // ----------------------------------------
    task automatic check_pixels(input int idx, input pixel_group_t got, input pixel_group_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: group %0d got %h ff %b le %b, expected %h ff %b le %b",
                     $time, idx, got.pixel, got.frame_first, got.line_end,
                     exp.pixel, exp.frame_first, exp.line_end);
        end
    endtask

    task automatic check_event(input string what, input int got_cnt, input int exp_cnt,
                               input logic [15:0] got_fn, input logic [15:0] exp_fn);
        checks++;
        if (got_cnt != exp_cnt) begin
            errors++;
            $display("mismatch at %0t: %s pulsed %0d times, expected %0d",
                     $time, what, got_cnt, exp_cnt);
        end else if (got_fn !== exp_fn) begin
            errors++;
            $display("mismatch at %0t: %s frame_number %h, expected %h",
                     $time, what, got_fn, exp_fn);
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // lanes produced nothing at all
    task automatic check_quiet(input string what);
        check_flag({what, ": pixel valid"}, pix_q.size() != 0, 1'b0);
        check_flag({what, ": frame_start"}, fs_count != 0, 1'b0);
        check_flag({what, ": frame_end"}, fe_count != 0, 1'b0);
        check_flag({what, ": ecc_error"}, ecc_count != 0, 1'b0);
        check_flag({what, ": termination"}, odt_cycles != 0, 1'b0);
        check_flag({what, ": aligner reset"}, drst_low != 0, 1'b0);
    endtask

    // ----------------------------------------
    // waits and drivers
    // ----------------------------------------
    task automatic wait_pixels(input int n);
        int cycles;
        cycles = 0;
        while (pix_q.size() < n && cycles < TIMEOUT_CYCLES) begin
            @(posedge dphy_rx_clk);
            cycles++;
        end
        if (pix_q.size() < n) begin
            errors++;
            $display("timeout at %0t: only %0d of %0d pixel groups arrived",
                     $time, pix_q.size(), n);
        end
    endtask

    task automatic wait_events(input int fs, input int fe, input int ecc);
        int cycles;
        cycles = 0;
        while (!(fs_count >= fs && fe_count >= fe && ecc_count >= ecc) &&
               cycles < TIMEOUT_CYCLES) begin
            @(posedge dphy_rx_clk);
            cycles++;
        end
        if (!(fs_count >= fs && fe_count >= fe && ecc_count >= ecc)) begin
            errors++;
            $display("timeout at %0t: frame events or ecc errors did not arrive", $time);
        end
    endtask

    task automatic idle(input int n);
        repeat (n) @(negedge dphy_rx_clk);
    endtask

    task automatic clear_counts();
        pix_q.delete();
        fs_count     = 0;
        fe_count     = 0;
        ecc_count    = 0;
        odt_cycles   = 0;
        odt_both     = 0;
        drst_low     = 0;
        event_number = '0;
    endtask

    task automatic drive_lp(input lp_state_t s, input int n);
        repeat (n) begin
            @(negedge dphy_rx_clk);
            lp_d0 = s;
            lp_d1 = s;
        end
    endtask

    // even bytes on lane 0, odd bytes on lane 1
    task automatic send_burst(input bit entry);
        int i;
        if (entry) begin
            drive_lp(LP_11, 4);
            drive_lp(LP_01, 4);
            drive_lp(LP_00, 4);
        end
        @(negedge dphy_rx_clk);
        hs_valid = 1'b1;
        hs_d0    = {8'h00, SYNC_BYTE};
        hs_d1    = {8'h00, SYNC_BYTE};
        for (i = 0; i < tx_bytes.size(); i += 2) begin
            @(negedge dphy_rx_clk);
            hs_d0 = {8'h00, tx_bytes[i]};
            hs_d1 = {8'h00, tx_bytes[i + 1]};
        end
        @(negedge dphy_rx_clk);
        hs_valid = 1'b0;
        hs_d0    = '0;
        hs_d1    = '0;
        lp_d0    = LP_11;
        lp_d1    = LP_11;
        idle(4);
    endtask

    task automatic add_header(input csi2_dt_t dt, input logic [15:0] field,
                              input logic [7:0] flip);
        logic [7:0] di;
        di = {2'b00, dt};                   // virtual channel 0
        tx_bytes.push_back(di);
        tx_bytes.push_back(field[7:0]);
        tx_bytes.push_back(field[15:8]);
        tx_bytes.push_back({2'b00, csi2_ecc({field, di})} ^ flip);
    endtask

    task automatic build_short(input csi2_dt_t dt, input logic [15:0] number,
                               input logic [7:0] flip);
        tx_bytes.delete();
        add_header(dt, number, flip);
    endtask

    // four high bytes, then the lsb byte with pixel 0 in bits 1:0
    task automatic build_raw(input csi2_dt_t dt, input logic [7:0] flip);
        logic [31:0] r;
        int          g;
        int          p;
        tx_bytes.delete();
        add_header(dt, 16'd20, flip);
        for (g = 0; g < 4; g++) begin
            for (p = 0; p < 4; p++)
                tx_bytes.push_back(pix_vals[4 * g + p][9:2]);
            tx_bytes.push_back({pix_vals[4 * g + 3][1:0], pix_vals[4 * g + 2][1:0],
                                pix_vals[4 * g + 1][1:0], pix_vals[4 * g][1:0]});
        end
        r = $random(seed);
        tx_bytes.push_back(r[7:0]);         // crc bytes, not checked
        tx_bytes.push_back(r[15:8]);
    endtask

    task automatic new_pixels();
        logic [31:0] r;
        int          i;
        for (i = 0; i < 16; i++) begin
            r           = $random(seed);
            pix_vals[i] = r[9:0];
        end
    endtask

    // ----------------------------------------
    // directed tests
    // ----------------------------------------
    task automatic test_idle_after_reset();
        clear_counts();
        idle(20);
        check_quiet("idle after reset");
    endtask

    task automatic test_frame_events();
        clear_counts();
        build_short(DT_FRAME_START, FRAME_NO, 8'h00);
        send_burst(1'b1);
        wait_events(1, 0, 0);
        idle(5);
        check_event("frame_start", fs_count, 1, event_number, FRAME_NO);
        check_flag("single aligner reset pulse", drst_low == 1, 1'b1);
        check_flag("termination on both lanes", odt_both != 0, 1'b1);
        check_flag("termination back in LP-11", hsrx_odten != 2'b00, 1'b0);
        clear_counts();
        build_short(DT_FRAME_END, FRAME_NO, 8'h00);
        send_burst(1'b1);
        wait_events(0, 1, 0);
        idle(5);
        check_event("frame_end", fe_count, 1, event_number, FRAME_NO);
        check_flag("frame_start on frame end packet", fs_count != 0, 1'b0);
        check_flag("ecc_error on good headers", ecc_count != 0, 1'b0);
    endtask

    task automatic test_raw10_line();
        pixel_group_t exp;
        int           g;
        int           p;
        clear_counts();
        new_pixels();
        build_short(DT_FRAME_START, FRAME_NO + 16'd1, 8'h00);
        send_burst(1'b1);
        build_raw(DT_RAW10, 8'h00);
        send_burst(1'b1);
        build_short(DT_FRAME_END, FRAME_NO + 16'd1, 8'h00);
        send_burst(1'b1);
        wait_pixels(4);
        wait_events(1, 1, 0);
        idle(5);
        check_flag("four pixel groups", pix_q.size() == 4, 1'b1);
        for (g = 0; g < 4 && g < pix_q.size(); g++) begin
            for (p = 0; p < 4; p++)
                exp.pixel[p] = pix_vals[4 * g + p];
            exp.frame_first = (g == 0);
            exp.line_end    = (g == 3);
            exp.valid       = 1'b1;
            check_pixels(g, pix_q[g], exp);
        end
        check_event("frame_end", fe_count, 1, event_number, FRAME_NO + 16'd1);
    endtask

    task automatic test_bad_ecc();
        clear_counts();
        build_short(DT_FRAME_START, FRAME_NO, 8'h04);
        send_burst(1'b1);
        build_raw(DT_RAW10, 8'h01);
        send_burst(1'b1);
        build_short(DT_FRAME_END, FRAME_NO, 8'h10);
        send_burst(1'b1);
        wait_events(0, 0, 3);
        idle(10);
        check_flag("three ecc errors", ecc_count == 3, 1'b1);
        check_flag("pixels after bad ecc", pix_q.size() != 0, 1'b0);
        check_flag("frame_start after bad ecc", fs_count != 0, 1'b0);
        check_flag("frame_end after bad ecc", fe_count != 0, 1'b0);
    endtask

    task automatic test_other_type();
        clear_counts();
        build_raw(6'h2A, 8'h00);            // raw8 code, not forwarded
        send_burst(1'b1);
        idle(30);
        check_flag("pixels for data type 0x2A", pix_q.size() != 0, 1'b0);
        check_flag("ecc_error for data type 0x2A", ecc_count != 0, 1'b0);
    endtask

    task automatic test_no_entry();
        idle(30);                           // let the last window close
        clear_counts();
        build_short(DT_FRAME_START, FRAME_NO, 8'h00);
        send_burst(1'b0);
        build_raw(DT_RAW10, 8'h00);
        send_burst(1'b0);
        idle(30);
        check_quiet("hs without lp entry");
    endtask

    initial begin
        seed     = 32'he873b7cd;
        errors   = 0;
        checks   = 0;
        in_reset = 1'b1;
        lp_d0    = LP_11;
        lp_d1    = LP_11;
        hs_d0    = '0;
        hs_d1    = '0;
        hs_valid = 1'b0;
        clear_counts();
        repeat (16) @(negedge dphy_rx_clk);
        in_reset = 1'b0;

        test_idle_after_reset();
        test_frame_events();
        test_raw10_line();
        test_bad_ecc();
        test_other_type();
        test_no_entry();

        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== design/csi2_rx_top.sv ====
`timescale 1ns/1ps

module csi2_rx_top #(
    parameter int                 HS_SETTLE_CYCLES = 10,
    parameter csi2_pkg::csi2_dt_t PIXEL_DATA_TYPE  = csi2_pkg::DT_RAW10
) (
    input  logic                   dphy_rx_clk,
    input  logic                   in_reset,
    input  dphy_pkg::lp_state_t    lp_d0,
    input  dphy_pkg::lp_state_t    lp_d1,
    input  logic [15:0]            hs_d0,
    input  logic [15:0]            hs_d1,
    input  logic                   hs_valid,
    output logic [1:0]             hsrx_odten,
    output logic                   drst_n,
    output csi2_pkg::pixel_group_t pixels,
    output logic                   frame_start,
    output logic                   frame_end,
    output logic [15:0]            frame_number,
    output logic                   ecc_error
);

    import dphy_pkg::*;
    import csi2_pkg::*;

    lane_bytes_t  lane_bytes;
    stream_beat_t framed_beat;      // sync pair removed
    stream_beat_t payload_beat;     // pixel payload only

    // -------------------------------------
    // byte path
    // -------------------------------------
    dphy_lane_ctrl #(
        .HS_SETTLE_CYCLES (HS_SETTLE_CYCLES)
    ) dphy_lane_ctrl_inst (
        .dphy_rx_clk (dphy_rx_clk),
        .in_reset    (in_reset),
        .lp_d0       (lp_d0),
        .lp_d1       (lp_d1),
        .hs_d0       (hs_d0),
        .hs_d1       (hs_d1),
        .hs_valid    (hs_valid),
        .hsrx_odten  (hsrx_odten),
        .drst_n      (drst_n),
        .lane_bytes  (lane_bytes)
    );

    hs_burst_framer hs_burst_framer_inst (
        .dphy_rx_clk (dphy_rx_clk),
        .in_reset    (in_reset),
        .lane_bytes  (lane_bytes),
        .beat        (framed_beat)
    );

    // -------------------------------------
    // packet and pixel path
    // -------------------------------------
    csi2_packet_parser #(
        .PIXEL_DATA_TYPE (PIXEL_DATA_TYPE)
    ) csi2_packet_parser_inst (
        .dphy_rx_clk  (dphy_rx_clk),
        .in_reset     (in_reset),
        .beat_in      (framed_beat),
        .payload      (payload_beat),
        .frame_start  (frame_start),
        .frame_end    (frame_end),
        .ecc_error    (ecc_error),
        .frame_number (frame_number)
    );

    raw10_unpacker raw10_unpacker_inst (
        .dphy_rx_clk (dphy_rx_clk),
        .in_reset    (in_reset),
        .payload     (payload_beat),
        .frame_start (frame_start),
        .pixels      (pixels)
    );

endmodule

// ==== design/raw10_unpacker.sv ====
`timescale 1ns/1ps

module raw10_unpacker (
    input  logic                   dphy_rx_clk,
    input  logic                   in_reset,
    input  csi2_pkg::stream_beat_t payload,
    input  logic                   frame_start,
    output csi2_pkg::pixel_group_t pixels
);

    logic [3:0][7:0] acc;           // bytes of the open group
    logic [2:0]      fill;          // 0..4 bytes in acc
    logic [2:0]      base;
    logic [5:0][7:0] merged;
    logic            group_done;
    logic            frame_pend;
    logic            grp_valid;
    logic            grp_first;
    logic            grp_end;
    logic [3:0][9:0] grp_pix;

    assign base       = payload.first ? 3'd0 : fill;   // new line starts empty
    assign group_done = payload.valid && (base >= 3'd3);

    always_comb begin
        merged = '0;
        for (int i = 0; i < 4; i++) begin
            if (i < base)
                merged[i] = acc[i];
        end
        merged[base]        = payload.data0;
        merged[base + 3'd1] = payload.data1;
    end

    always_ff @(posedge dphy_rx_clk or posedge in_reset) begin
        if (in_reset) begin
            fill       <= '0;
            frame_pend <= 1'b0;
            grp_valid  <= 1'b0;
            grp_first  <= 1'b0;
            grp_end    <= 1'b0;
        end else begin
            if (payload.valid)
                fill <= group_done ? base - 3'd3 : base + 3'd2;   // 4 leaves one over
            if (frame_start)
                frame_pend <= 1'b1;
            else if (group_done)
                frame_pend <= 1'b0;
            grp_valid <= group_done;
            grp_first <= group_done && frame_pend;
            grp_end   <= group_done && payload.last;
        end
    end

    always_ff @(posedge dphy_rx_clk) begin
        if (payload.valid) begin
            if (group_done)
                acc[0] <= merged[5];   // carry byte into next group
            else
                acc <= merged[3:0];
        end
        if (group_done) begin
            for (int p = 0; p < 4; p++)
                grp_pix[p] <= {merged[p], merged[4][2*p +: 2]};   // lsbs from byte 4
        end
    end

    assign pixels = '{
        pixel:       grp_pix,
        frame_first: grp_first,
        line_end:    grp_end,
        valid:       grp_valid
    };

    // a line always ends on a group boundary
    assert property (@(posedge dphy_rx_clk) disable iff (in_reset)
        (payload.valid && payload.last) |=> (fill == 3'd0));

endmodule

// ==== design/csi2_packet_parser.sv ====
`timescale 1ns/1ps

module csi2_packet_parser #(
    parameter csi2_pkg::csi2_dt_t PIXEL_DATA_TYPE = csi2_pkg::DT_RAW10
) (
    input  logic                   dphy_rx_clk,
    input  logic                   in_reset,
    input  csi2_pkg::stream_beat_t beat_in,
    output csi2_pkg::stream_beat_t payload,
    output logic                   frame_start,
    output logic                   frame_end,
    output logic                   ecc_error,
    output logic [15:0]            frame_number
);

    import csi2_pkg::*;

    localparam logic [1:0] ST_IDLE    = 2'd0;
    localparam logic [1:0] ST_HDR     = 2'd1;  // second header beat expected
    localparam logic [1:0] ST_PAYLOAD = 2'd2;
    localparam logic [1:0] ST_CRC     = 2'd3;

    logic [1:0]   state;
    logic [7:0]   hdr_di;         // data identifier
    logic [7:0]   hdr_wc_lo;
    csi2_header_t hdr;
    logic         hdr_done;
    logic         ecc_ok;
    logic         frame_evt;
    logic         take_payload;
    logic         pay_take;
    logic [14:0]  beats_left;
    logic         line_start;
    logic         pay_valid;
    logic         pay_first;
    logic         pay_last;
    logic [7:0]   pay_d0;
    logic [7:0]   pay_d1;

    // lane 0 brings DI then WC high, lane 1 brings WC low then ECC
    assign hdr = csi2_header_t'({hdr_di, beat_in.data0, hdr_wc_lo, beat_in.data1});

    assign hdr_done     = (state == ST_HDR) && beat_in.valid && !beat_in.first;
    assign ecc_ok       = (hdr.ecc == {2'b00, csi2_ecc({hdr.field, hdr.vc, hdr.dt})});
    assign frame_evt    = hdr_done && ecc_ok && (hdr.vc == 2'd0) &&
                          ((hdr.dt == DT_FRAME_START) || (hdr.dt == DT_FRAME_END));
    assign take_payload = ecc_ok && (hdr.dt[5:4] != 2'b00) && (hdr.vc == 2'd0) &&
                          (hdr.dt == PIXEL_DATA_TYPE) &&
                          (hdr.field.word_count[15:1] != '0);
    assign pay_take     = (state == ST_PAYLOAD) && beat_in.valid && !beat_in.first;

    // -------------------------------------
    // packet fsm
    // -------------------------------------
    always_ff @(posedge dphy_rx_clk or posedge in_reset) begin
        if (in_reset) begin
            state      <= ST_IDLE;
            beats_left <= '0;
            line_start <= 1'b0;
        end else if (beat_in.valid) begin
            if (beat_in.first) begin
                state <= ST_HDR;        // every burst opens with a header
            end else begin
                case (state)
                    ST_HDR: begin
                        state      <= take_payload ? ST_PAYLOAD : ST_IDLE;
                        beats_left <= hdr.field.word_count[15:1];
                        line_start <= 1'b1;
                    end
                    ST_PAYLOAD: begin
                        beats_left <= beats_left - 1'b1;
                        line_start <= 1'b0;
                        if (beats_left == 15'd1)
                            state <= ST_CRC;
                    end
                    default: state <= ST_IDLE;    // crc beat or stray data
                endcase
                if (beat_in.last)
                    state <= ST_IDLE;
            end
        end
    end

    always_ff @(posedge dphy_rx_clk or posedge in_reset) begin
        if (in_reset) begin
            frame_start  <= 1'b0;
            frame_end    <= 1'b0;
            ecc_error    <= 1'b0;
            frame_number <= '0;
            pay_valid    <= 1'b0;
            pay_first    <= 1'b0;
            pay_last     <= 1'b0;
        end else begin
            frame_start <= frame_evt && (hdr.dt == DT_FRAME_START);
            frame_end   <= frame_evt && (hdr.dt == DT_FRAME_END);
            ecc_error   <= hdr_done && !ecc_ok;
            if (frame_evt)
                frame_number <= hdr.field.frame_number;
            pay_valid <= pay_take;
            pay_first <= pay_take && line_start;
            pay_last  <= pay_take && (beats_left == 15'd1);
        end
    end

    always_ff @(posedge dphy_rx_clk) begin
        if (beat_in.valid && beat_in.first) begin
            hdr_di    <= beat_in.data0;
            hdr_wc_lo <= beat_in.data1;
        end
        pay_d0 <= beat_in.data0;
        pay_d1 <= beat_in.data1;
    end

    assign payload = '{
        data1: pay_d1,
        data0: pay_d0,
        first: pay_first,
        last:  pay_last,
        valid: pay_valid
    };

    // the crc beat always closes a line
    assert property (@(posedge dphy_rx_clk) disable iff (in_reset)
        (payload.valid && payload.last) |=> !payload.valid);

endmodule

// ==== design/hs_burst_framer.sv ====
`timescale 1ns/1ps

module hs_burst_framer (
    input  logic                   dphy_rx_clk,
    input  logic                   in_reset,
    input  dphy_pkg::lane_bytes_t  lane_bytes,
    output csi2_pkg::stream_beat_t beat
);

    localparam logic [7:0] SYNC_BYTE = 8'hB8;

    logic       in_active;      // input valid last cycle
    logic       sync_drop;
    logic       hold_valid;
    logic       hold_first;
    logic [7:0] hold_d0;
    logic [7:0] hold_d1;

    // leading sync pair of a burst
    assign sync_drop = lane_bytes.valid && !in_active &&
                       (lane_bytes.d0 == SYNC_BYTE) && (lane_bytes.d1 == SYNC_BYTE);

    always_ff @(posedge dphy_rx_clk or posedge in_reset) begin
        if (in_reset) begin
            in_active  <= 1'b0;
            hold_valid <= 1'b0;
            hold_first <= 1'b0;
        end else begin
            in_active  <= lane_bytes.valid;
            hold_valid <= lane_bytes.valid && !sync_drop;
            hold_first <= lane_bytes.valid && !sync_drop && !hold_valid;
        end
    end

    always_ff @(posedge dphy_rx_clk) begin
        hold_d0 <= lane_bytes.d0;
        hold_d1 <= lane_bytes.d1;
    end

    // held beat is last when nothing follows it
    assign beat = '{
        data1: hold_d1,
        data0: hold_d0,
        first: hold_first,
        last:  hold_valid && !lane_bytes.valid,
        valid: hold_valid
    };

endmodule

// ==== design/dphy_lane_ctrl.sv ====
`timescale 1ns/1ps

module dphy_lane_ctrl #(
    parameter int HS_SETTLE_CYCLES = 10
) (
    input  logic                  dphy_rx_clk,
    input  logic                  in_reset,
    input  dphy_pkg::lp_state_t   lp_d0,
    input  dphy_pkg::lp_state_t   lp_d1,
    input  logic [15:0]           hs_d0,
    input  logic [15:0]           hs_d1,
    input  logic                  hs_valid,
    output logic [1:0]            hsrx_odten,
    output logic                  drst_n,
    output dphy_pkg::lane_bytes_t lane_bytes
);

    import dphy_pkg::*;

    localparam int CNT_W = $clog2(HS_SETTLE_CYCLES + 1);

    lp_state_t        lp_q0;            // newest lane-0 sample
    lp_state_t        lp_q1;            // one cycle older
    logic             from_11_to_01;
    logic             from_01_to_00;
    logic             from_01_to_10;
    logic             leave_01;
    logic             odt_arm;
    logic             req_seen;         // waiting for the LP-00 step
    logic [CNT_W-1:0] settle_cnt;
    logic             hs_window;
    logic             byte_valid;
    logic [7:0]       byte_d0;
    logic [7:0]       byte_d1;

    // -------------------------------------
    // lp history
    // -------------------------------------
    assign from_11_to_01 = (lp_q1 == LP_11) && (lp_q0 == LP_01);
    assign from_01_to_00 = (lp_q1 == LP_01) && (lp_q0 == LP_00);
    assign from_01_to_10 = (lp_q1 == LP_01) && (lp_q0 == ~LP_01);  // ~LP_01 is LP-10
    assign leave_01      = (lp_q1 == LP_01) && (lp_q0 != LP_01);

    always_ff @(posedge dphy_rx_clk or posedge in_reset) begin
        if (in_reset) begin
            lp_q0 <= LP_11;
            lp_q1 <= LP_11;
        end else begin
            lp_q0 <= lp_d0;
            lp_q1 <= lp_q0;
        end
    end

    always_ff @(posedge dphy_rx_clk or posedge in_reset) begin
        if (in_reset) begin
            odt_arm  <= 1'b0;
            req_seen <= 1'b0;
            drst_n   <= 1'b1;
        end else begin
            if (!odt_arm)
                odt_arm <= from_11_to_01;
            else
                odt_arm <= !(from_01_to_10 || (lp_q0 == LP_11));   // aborted request
            if (!req_seen)
                req_seen <= from_11_to_01;
            else
                req_seen <= !leave_01;
            drst_n <= !(req_seen && from_01_to_00);    // one-cycle aligner reset
        end
    end

    // per-lane termination once the lane sits in LP-00
    assign hsrx_odten = {lp_d1 == LP_00, lp_d0 == LP_00} & {2{odt_arm}};

    // -------------------------------------
    // settle window and capture
    // -------------------------------------
    always_ff @(posedge dphy_rx_clk or posedge in_reset) begin
        if (in_reset) begin
            settle_cnt <= '0;
            hs_window  <= 1'b0;
            byte_valid <= 1'b0;
        end else begin
            if (|hsrx_odten)
                settle_cnt <= CNT_W'(HS_SETTLE_CYCLES);
            else if (settle_cnt != '0)
                settle_cnt <= settle_cnt - 1'b1;
            hs_window  <= (settle_cnt != '0);
            byte_valid <= hs_window && hs_valid;
        end
    end

    always_ff @(posedge dphy_rx_clk) begin
        byte_d0 <= hs_d0[7:0];     // phy runs in 8-bit mode
        byte_d1 <= hs_d1[7:0];
    end

    assign lane_bytes = '{d1: byte_d1, d0: byte_d0, valid: byte_valid};

    // window only opens out of termination
    assert property (@(posedge dphy_rx_clk) disable iff (in_reset)
        $rose(hs_window) |-> $past(|hsrx_odten, 2));

endmodule

// ==== design/csi2_pkg.sv ====
package csi2_pkg;

    typedef logic [5:0] csi2_dt_t;

    localparam csi2_dt_t DT_FRAME_START = 6'h00;
    localparam csi2_dt_t DT_FRAME_END   = 6'h01;
    localparam csi2_dt_t DT_RAW10       = 6'h2B;

    // meaning depends on the packet class
    typedef union packed {
        logic [15:0] word_count;    // long packet, payload bytes
        logic [15:0] frame_number;  // FS and FE short packets
    } csi2_hdr_field_u;

    typedef struct packed {
        logic [1:0]      vc;
        csi2_dt_t        dt;
        csi2_hdr_field_u field;
        logic [7:0]      ecc;       // top two bits always zero
    } csi2_header_t;

    typedef struct packed {
        logic [7:0] data1;      // odd byte
        logic [7:0] data0;      // even byte
        logic       first;
        logic       last;
        logic       valid;
    } stream_beat_t;

    typedef struct packed {
        logic [3:0][9:0] pixel;
        logic            frame_first;
        logic            line_end;
        logic            valid;
    } pixel_group_t;

    // -------------------------------------
    // header ecc
    // -------------------------------------
    // d[7:0] is the data identifier, d[23:8] the header field
    function automatic logic [5:0] csi2_ecc(input logic [23:0] d);
        logic [5:0] p;
        p[0] = ^(d & 24'hF12CB7);
        p[1] = ^(d & 24'hF2555B);
        p[2] = ^(d & 24'h749A6D);
        p[3] = ^(d & 24'hB8E38E);
        p[4] = ^(d & 24'hDF03F0);
        p[5] = ^(d & 24'hEFFC00);
        return p;
    endfunction

endpackage

// ==== design/dphy_pkg.sv ====
package dphy_pkg;

    // low-power level of one lane, {p, n}
    typedef logic [1:0] lp_state_t;

    localparam lp_state_t LP_11 = 2'b11;    // stop state
    localparam lp_state_t LP_01 = 2'b01;    // hs request
    localparam lp_state_t LP_00 = 2'b00;    // bridge, then hs

    // -------------------------------------
    // captured lane bytes
    // -------------------------------------
    typedef struct packed {
        logic [7:0] d1;     // lane 1, odd bytes
        logic [7:0] d0;     // lane 0, even bytes
        logic       valid;
    } lane_bytes_t;

endpackage
